//--- project.f
common/mult_pkg.sv
hdl/int_mac.sv
short_mult/short_mult_datapath.sv
short_mult/mulh_sequencer.sv
hdl/mult_top.sv
verif/mult_checker.sv
verif/mult_monitor.sv
verif/tb_mult.sv

//--- Makefile
TOP := tb_mult

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f project.f -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_mult.sv
////////////////////////////////////////////////////////////
// multiplier testbench
// table driven stimulus over all five opcodes, mulh rows
// with back-pressure, results compared in the monitor
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_mult;

  localparam int ROWS           = 27;
  localparam int FIXED_ROWS     = 17;
  // each row takes at most 8 cycles, ten times that as margin
  localparam int TIMEOUT_CYCLES = 10 * ROWS * 8;

  logic               clk;
  logic               rst_n;
  logic               enable;
  mult_pkg::mult_op_e op_sel;
  logic               subword;
  logic [1:0]         signed_mode;
  logic [31:0]        op_a;
  logic [31:0]        op_b;
  logic [31:0]        op_c;
  logic [4:0]         imm;
  logic               ex_ready;
  logic [31:0]        result;
  logic               multicycle;
  logic               ready;
  logic [31:0]        exp_result;

  // counters kept by the monitor
  int unsigned checks;
  int unsigned result_errors;
  int unsigned status_errors;

  // stimulus table
  // hold is the number of extra FINISH cycles with ex_ready low
  mult_pkg::mult_op_e tbl_op   [ROWS];
  logic [31:0]        tbl_a    [ROWS];
  logic [31:0]        tbl_b    [ROWS];
  logic [31:0]        tbl_c    [ROWS];
  logic [4:0]         tbl_imm  [ROWS];
  logic               tbl_sub  [ROWS];
  logic [1:0]         tbl_sgn  [ROWS];
  logic [31:0]        tbl_exp  [ROWS];
  int unsigned        tbl_hold [ROWS];

  logic [31:0] lfsr_state;
  int unsigned cycle_count;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  mult_top dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable),
    .operator_i      (op_sel),
    .short_subword_i (subword),
    .short_signed_i  (signed_mode),
    .op_a_i          (op_a),
    .op_b_i          (op_b),
    .op_c_i          (op_c),
    .imm_i           (imm),
    .result_o        (result),
    .multicycle_o    (multicycle),
    .ready_o         (ready),
    .ex_ready_i      (ex_ready)
  );

  mult_monitor mon0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable),
    .operator_i      (op_sel),
    .result_i        (result),
    .ready_i         (ready),
    .multicycle_i    (multicycle),
    .exp_result_i    (exp_result),
    .checks_o        (checks),
    .result_errors_o (result_errors),
    .status_errors_o (status_errors)
  );

  bind mulh_sequencer mult_checker chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .state_i      (state_q),
    .enable_i     (enable_i),
    .operator_i   (operator_i),
    .ex_ready_i   (ex_ready_i),
    .ready_i      (ready_o),
    .multicycle_i (multicycle_o)
  );

  ////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] take_random_bits(input int unsigned count);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int k = 0; k < count; k++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value      = {value[30:0], fb};
    end
    return value;
  endfunction

  // low word of c plus or minus a*b
  function automatic logic [31:0] int_mac_rule(input mult_pkg::mult_op_e op,
                                               input logic [31:0] a, b, c);
    logic [31:0] prod;
    prod = a * b;
    if (op == mult_pkg::MUL_MSU32) begin
      return c - prod;
    end
    return c + prod;
  endfunction

  // one half of each operand, extended by its sign bit, then add c and round
  function automatic logic [31:0] subword_rule(input logic round, input logic [31:0] a, b, c,
                                               input logic [4:0] sh, input logic sub,
                                               input logic [1:0] sgn);
    logic [15:0] ah;
    logic [15:0] bh;
    logic [31:0] ax;
    logic [31:0] bx;
    logic [31:0] rnd;
    logic [31:0] sum;
    logic [31:0] res;
    ah  = sub ? a[31:16] : a[15:0];
    bh  = sub ? b[31:16] : b[15:0];
    ax  = {{16{sgn[0] & ah[15]}}, ah};
    bx  = {{16{sgn[1] & bh[15]}}, bh};
    rnd = (round && sh != 5'd0) ? (32'd1 << (sh - 5'd1)) : 32'd0;
    sum = c + ax * bx + rnd;
    if (sgn[0]) begin
      res = $signed(sum) >>> sh;
    end else begin
      res = sum >> sh;
    end
    return res;
  endfunction

  // bits 63..32 of the full product, sign per operand
  function automatic logic [31:0] high_word_rule(input logic [31:0] a, b,
                                                 input logic [1:0] sgn);
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] prod;
    ax   = {{32{sgn[0] & a[31]}}, a};
    bx   = {{32{sgn[1] & b[31]}}, b};
    prod = ax * bx;
    return prod[63:32];
  endfunction

  task automatic set_row(input int i, input mult_pkg::mult_op_e op,
                         input logic [31:0] a, b, c, input logic [4:0] sh,
                         input logic sub, input logic [1:0] sgn, input int unsigned hold);
    tbl_op[i]   = op;
    tbl_a[i]    = a;
    tbl_b[i]    = b;
    tbl_c[i]    = c;
    tbl_imm[i]  = sh;
    tbl_sub[i]  = sub;
    tbl_sgn[i]  = sgn;
    tbl_hold[i] = hold;
    case (op)
      mult_pkg::MUL_MAC32, mult_pkg::MUL_MSU32: tbl_exp[i] = int_mac_rule(op, a, b, c);
      mult_pkg::MUL_I:  tbl_exp[i] = subword_rule(1'b0, a, b, c, sh, sub, sgn);
      mult_pkg::MUL_IR: tbl_exp[i] = subword_rule(1'b1, a, b, c, sh, sub, sgn);
      default:          tbl_exp[i] = high_word_rule(a, b, sgn);
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // table
  ////////////////////////////////////////////////////////////

  task automatic fill_table();
    mult_pkg::mult_op_e op;
    logic [1:0]         mode;
    logic [31:0]        bits;
    logic [31:0]        rnd_a;
    logic [31:0]        rnd_b;
    logic [31:0]        rnd_c;
    logic [4:0]         rnd_imm;
    logic               rnd_sub;
    lfsr_state = 32'h3437b95d;
    // corner values
    set_row(0, mult_pkg::MUL_MAC32, 32'h3, 32'h5, 32'h7, 5'd0, 1'b0, 2'b00, 0);
    set_row(1, mult_pkg::MUL_MAC32, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0000,
            5'd0, 1'b0, 2'b00, 0);
    set_row(2, mult_pkg::MUL_MSU32, 32'h8000_0000, 32'hFFFF_FFFF, 32'h1, 5'd0, 1'b0, 2'b00, 0);
    set_row(3, mult_pkg::MUL_MSU32, 32'h1, 32'h1, 32'h0, 5'd0, 1'b0, 2'b00, 0);
    set_row(4, mult_pkg::MUL_I, 32'hFFFF_8000, 32'h0001_7FFF, 32'h0, 5'd4, 1'b0, 2'b11, 0);
    set_row(5, mult_pkg::MUL_I, 32'h8000_0001, 32'hFFFF_0000, 32'hFFFF_FFFF,
            5'd3, 1'b1, 2'b00, 0);
    set_row(6, mult_pkg::MUL_I, 32'h0000_FFFF, 32'h0000_FFFF, 32'h1, 5'd0, 1'b0, 2'b01, 0);
    set_row(7, mult_pkg::MUL_IR, 32'hFFFF_0001, 32'h8000_0000, 32'h0, 5'd1, 1'b1, 2'b11, 0);
    set_row(8, mult_pkg::MUL_IR, 32'h0000_FFFF, 32'h0000_FFFF, 32'h1, 5'd0, 1'b0, 2'b01, 0);
    set_row(9, mult_pkg::MUL_IR, 32'h0000_8000, 32'h0000_8000, 32'h8000_0000,
            5'd31, 1'b0, 2'b11, 0);
    set_row(10, mult_pkg::MUL_H, 32'h8000_0000, 32'h8000_0000, 32'h0, 5'd0, 1'b0, 2'b11, 0);
    set_row(11, mult_pkg::MUL_H, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 5'd0, 1'b0, 2'b01, 0);
    set_row(12, mult_pkg::MUL_H, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 5'd0, 1'b0, 2'b00, 3);
    set_row(13, mult_pkg::MUL_H, 32'hFFFF_FFFF, 32'h1, 32'h0, 5'd0, 1'b0, 2'b11, 0);
    // remaining subword and sign pairs, sum with bit 31 set
    set_row(14, mult_pkg::MUL_I, 32'h1234_FFFF, 32'h0000_8001, 32'h0, 5'd2, 1'b0, 2'b00, 0);
    set_row(15, mult_pkg::MUL_I, 32'h8000_1234, 32'hFFFF_5678, 32'h10, 5'd5, 1'b1, 2'b01, 0);
    set_row(16, mult_pkg::MUL_I, 32'hFFFF_0000, 32'h7FFF_0000, 32'h0, 5'd8, 1'b1, 2'b11, 0);
    // random operands, opcodes in turn, the last mulh under back-pressure
    for (int i = FIXED_ROWS; i < ROWS; i++) begin
      case ((i - FIXED_ROWS) % 5)
        0:       op = mult_pkg::MUL_MAC32;
        1:       op = mult_pkg::MUL_MSU32;
        2:       op = mult_pkg::MUL_I;
        3:       op = mult_pkg::MUL_IR;
        default: op = mult_pkg::MUL_H;
      endcase
      bits = take_random_bits(2);
      mode = bits[1:0];
      // 2'b10 is not a legal signed mode
      if (mode == 2'b10) begin
        mode = 2'b11;
      end
      rnd_a   = take_random_bits(32);
      rnd_b   = take_random_bits(32);
      rnd_c   = take_random_bits(32);
      bits    = take_random_bits(5);
      rnd_imm = bits[4:0];
      bits    = take_random_bits(1);
      rnd_sub = bits[0];
      set_row(i, op, rnd_a, rnd_b, rnd_c, rnd_imm, rnd_sub, mode, (i == ROWS - 1) ? 2 : 0);
    end
  endtask

  task automatic drive_row(input int i);
    enable      <= 1'b1;
    op_sel      <= tbl_op[i];
    op_a        <= tbl_a[i];
    op_b        <= tbl_b[i];
    op_c        <= tbl_c[i];
    imm         <= tbl_imm[i];
    subword     <= tbl_sub[i];
    signed_mode <= tbl_sgn[i];
    exp_result  <= tbl_exp[i];
    ex_ready    <= (tbl_hold[i] == 0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n       <= 1'b0;
    enable      <= 1'b0;
    op_sel      <= mult_pkg::MUL_MAC32;
    op_a        <= '0;
    op_b        <= '0;
    op_c        <= '0;
    imm         <= '0;
    subword     <= 1'b0;
    signed_mode <= 2'b00;
    exp_result  <= '0;
    ex_ready    <= 1'b1;
    fill_table();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < ROWS; i++) begin
      drive_row(i);
      @(posedge clk);
      if (tbl_op[i] == mult_pkg::MUL_H) begin
        // inputs stay put until the edge that leaves FINISH
        while (!ready) @(posedge clk);
        if (tbl_hold[i] > 0) begin
          repeat (tbl_hold[i] - 1) @(posedge clk);
          ex_ready <= 1'b1;
          @(posedge clk);
        end
      end
    end
    enable <= 1'b0;
    @(posedge clk);
    $display("checks %0d, result mismatches %0d, status mismatches %0d",
             checks, result_errors, status_errors);
    if (result_errors == 0 && status_errors == 0 && checks > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      if (checks == 0) begin
        $display("no result was checked by the monitor");
      end
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: test did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/mult_monitor.sv
////////////////////////////////////////////////////////////
// multiplier monitor
// samples the DUT at each enabled edge and compares the
// result and status outputs with the expected values
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mult_monitor (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               enable_i,
  input  mult_pkg::mult_op_e operator_i,
  input  logic [31:0]        result_i,
  input  logic               ready_i,
  input  logic               multicycle_i,
  input  logic [31:0]        exp_result_i,
  output int unsigned        checks_o,
  output int unsigned        result_errors_o,
  output int unsigned        status_errors_o
);

  logic sample_now;
  logic is_mulh;

  // combinational ops at once, mulh only once the high word is ready
  assign is_mulh    = (operator_i == mult_pkg::MUL_H);
  assign sample_now = enable_i && (!is_mulh || ready_i);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      checks_o        <= 0;
      result_errors_o <= 0;
      status_errors_o <= 0;
    end else if (sample_now) begin
      checks_o <= checks_o + 1;
      if (result_i !== exp_result_i) begin
        $display("Mismatch result_o exp=%08h got=%08h op=%s at %0t",
                 exp_result_i, result_i, operator_i.name(), $time);
        result_errors_o <= result_errors_o + 1;
      end
      // single cycle ops never stall the pipeline
      if (!is_mulh && (ready_i !== 1'b1 || multicycle_i !== 1'b0)) begin
        $display("Mismatch ready_o/multicycle_o exp=1/0 got=%h/%h at %0t",
                 ready_i, multicycle_i, $time);
        status_errors_o <= status_errors_o + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/mult_checker.sv
////////////////////////////////////////////////////////////
// mulh sequencer checker
// assertions on the ready/multicycle protocol and FINISH
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mult_checker (
  input logic                  clk,
  input logic                  rst_n,
  input mult_pkg::mulh_state_e state_i,
  input logic                  enable_i,
  input mult_pkg::mult_op_e    operator_i,
  input logic                  ex_ready_i,
  input logic                  ready_i,
  input logic                  multicycle_i
);

  logic mulh_start;

  assign mulh_start = (state_i == mult_pkg::IDLE) && enable_i &&
                      (operator_i == mult_pkg::MUL_H);

  // busy and ready exclude each other
  busy_xor_ready: assert property (@(posedge clk) disable iff (!rst_n)
      !(multicycle_i && ready_i))
    else $error("multicycle_o and ready_o high in the same cycle");

  // back-pressure keeps FINISH and ready_o
  finish_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (state_i == mult_pkg::FINISH && !ex_ready_i) |=>
      (state_i == mult_pkg::FINISH && ready_i))
    else $error("FINISH or ready_o lost while ex_ready_i was low");

  // three busy steps then FINISH
  mulh_steps: assert property (@(posedge clk) disable iff (!rst_n)
      mulh_start |=> multicycle_i ##1 multicycle_i ##1 multicycle_i
                     ##1 (state_i == mult_pkg::FINISH))
    else $error("mulh start not followed by three steps and FINISH");

endmodule

`default_nettype wire

//--- hdl/mult_top.sv
////////////////////////////////////////////////////////////
// multiplier top level
// integer MAC, subword multiplier and the multicycle
// high-word sequencer, result selected by opcode
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mult_top (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         enable_i,
  input  mult_pkg::mult_op_e           operator_i,

  // subword controls
  input  logic                         short_subword_i,
  input  logic [1:0]                   short_signed_i,

  input  logic [mult_pkg::DATA_W-1:0]  op_a_i,
  input  logic [mult_pkg::DATA_W-1:0]  op_b_i,
  input  logic [mult_pkg::DATA_W-1:0]  op_c_i,
  input  logic [mult_pkg::SHIFT_W-1:0] imm_i,

  output logic [mult_pkg::DATA_W-1:0]  result_o,
  output logic                         multicycle_o,
  output logic                         ready_o,
  input  logic                         ex_ready_i
);

  logic [mult_pkg::DATA_W-1:0]  int_result;
  logic [mult_pkg::DATA_W-1:0]  short_result;

  // sequencer to datapath
  logic                         mulh_active;
  logic [1:0]                   mulh_subword;
  logic [1:0]                   mulh_signed;
  logic [mult_pkg::SHIFT_W-1:0] mulh_imm;
  logic                         mulh_shift_arith;
  logic                         mulh_carry;
  logic                         mac_carry;

  // running partial sum of the high-word steps
  logic [mult_pkg::DATA_W-1:0]  mulh_acc_q;

  int_mac u_int_mac (
    .operator_i (operator_i),
    .op_a_i     (op_a_i),
    .op_b_i     (op_b_i),
    .op_c_i     (op_c_i),
    .result_o   (int_result)
  );

  short_mult_datapath u_short (
    .operator_i         (operator_i),
    .op_a_i             (op_a_i),
    .op_b_i             (op_b_i),
    .op_c_i             (op_c_i),
    .imm_i              (imm_i),
    .short_subword_i    (short_subword_i),
    .short_signed_i     (short_signed_i),
    .mulh_active_i      (mulh_active),
    .mulh_subword_i     (mulh_subword),
    .mulh_signed_i      (mulh_signed),
    .mulh_imm_i         (mulh_imm),
    .mulh_shift_arith_i (mulh_shift_arith),
    .mulh_acc_i         (mulh_acc_q),
    .carry_i            (mulh_carry),
    .result_o           (short_result),
    .mac_carry_o        (mac_carry)
  );

  mulh_sequencer u_mulh (
    .clk                (clk),
    .rst_n              (rst_n),
    .enable_i           (enable_i),
    .operator_i         (operator_i),
    .short_signed_i     (short_signed_i),
    .ex_ready_i         (ex_ready_i),
    .mac_carry_i        (mac_carry),
    .mulh_active_o      (mulh_active),
    .mulh_subword_o     (mulh_subword),
    .mulh_signed_o      (mulh_signed),
    .mulh_imm_o         (mulh_imm),
    .mulh_shift_arith_o (mulh_shift_arith),
    .carry_o            (mulh_carry),
    .ready_o            (ready_o),
    .multicycle_o       (multicycle_o)
  );

  // zero before STEP0, takes each step result, held through FINISH
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mulh_acc_q <= '0;
    end else if (!mulh_active) begin
      mulh_acc_q <= '0;
    end else if (multicycle_o) begin
      mulh_acc_q <= short_result;
    end
  end

  ////////////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    unique case (operator_i)
      mult_pkg::MUL_MAC32, mult_pkg::MUL_MSU32: result_o = int_result;
      mult_pkg::MUL_I, mult_pkg::MUL_IR, mult_pkg::MUL_H: result_o = short_result;
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- short_mult/mulh_sequencer.sv
////////////////////////////////////////////////////////////
// high-word multiply sequencer
// steps mulh/mulhsu/mulhu through four 16-bit partial
// products, keeps the carry between steps, drives ready
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mulh_sequencer (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         enable_i,
  input  mult_pkg::mult_op_e           operator_i,
  input  logic [1:0]                   short_signed_i,
  input  logic                         ex_ready_i,
  input  logic                         mac_carry_i,

  // step controls to the datapath
  output logic                         mulh_active_o,
  output logic [1:0]                   mulh_subword_o,
  output logic [1:0]                   mulh_signed_o,
  output logic [mult_pkg::SHIFT_W-1:0] mulh_imm_o,
  output logic                         mulh_shift_arith_o,
  output logic                         carry_o,

  output logic                         ready_o,
  output logic                         multicycle_o
);

  mult_pkg::mulh_state_e state_q;
  mult_pkg::mulh_state_e state_d;

  logic mulh_start;
  logic carry_q;
  logic carry_save;
  logic carry_clear;

  assign mulh_start = enable_i && (operator_i == mult_pkg::MUL_H);

  ////////////////////////////////////////////////////////////
  // next-state logic
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      mult_pkg::IDLE: begin
        if (mulh_start) begin
          state_d = mult_pkg::STEP0;
        end
      end
      mult_pkg::STEP0: state_d = mult_pkg::STEP1;
      mult_pkg::STEP1: state_d = mult_pkg::STEP2;
      mult_pkg::STEP2: state_d = mult_pkg::FINISH;
      mult_pkg::FINISH: begin
        // hold the result until the pipeline takes it
        if (ex_ready_i) begin
          state_d = mult_pkg::IDLE;
        end
      end
      default: state_d = mult_pkg::IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mult_pkg::IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (carry_save) begin
        carry_q <= ~carry_clear & mac_carry_i;
      end else if (ex_ready_i) begin
        // next instruction starts without a stale carry
        carry_q <= 1'b0;
      end
    end
  end

  assign carry_o = carry_q;

  ////////////////////////////////////////////////////////////
  // output decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    mulh_active_o      = 1'b1;
    mulh_subword_o     = 2'b00;
    mulh_signed_o      = 2'b00;
    mulh_imm_o         = '0;
    mulh_shift_arith_o = 1'b0;
    ready_o            = 1'b0;
    multicycle_o       = 1'b0;
    carry_save         = 1'b0;
    carry_clear        = 1'b0;

    unique case (state_q)
      mult_pkg::IDLE: begin
        mulh_active_o = 1'b0;
        // busy already in the start cycle
        ready_o       = !mulh_start;
      end
      mult_pkg::STEP0: begin
        // AL*BL is unsigned and never carries
        multicycle_o = 1'b1;
        mulh_imm_o   = mult_pkg::MULH_STEP_SHIFT;
      end
      mult_pkg::STEP1: begin
        // AL*BH signed only with B, 33 bit sum kept unshifted
        multicycle_o       = 1'b1;
        mulh_subword_o     = 2'b10;
        mulh_signed_o      = {short_signed_i[1], 1'b0};
        mulh_shift_arith_o = 1'b1;
        carry_save         = 1'b1;
      end
      mult_pkg::STEP2: begin
        // AH*BL signed only with A
        // bits 33:32 are shifted back in so the carry is dropped
        multicycle_o       = 1'b1;
        mulh_subword_o     = 2'b01;
        mulh_signed_o      = {1'b0, short_signed_i[0]};
        mulh_imm_o         = mult_pkg::MULH_STEP_SHIFT;
        mulh_shift_arith_o = 1'b1;
        carry_save         = 1'b1;
        carry_clear        = 1'b1;
      end
      mult_pkg::FINISH: begin
        // AH*BH with both signs, result valid here
        mulh_subword_o = 2'b11;
        mulh_signed_o  = short_signed_i;
        ready_o        = 1'b1;
      end
      default: begin
        mulh_active_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- short_mult/short_mult_datapath.sv
////////////////////////////////////////////////////////////
// subword multiplier datapath
// 17x17 multiply of selected halves, accumulate, optional
// rounding and right shift, also runs the mulh steps
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module short_mult_datapath (
  input  mult_pkg::mult_op_e           operator_i,
  input  logic [mult_pkg::DATA_W-1:0]  op_a_i,
  input  logic [mult_pkg::DATA_W-1:0]  op_b_i,
  input  logic [mult_pkg::DATA_W-1:0]  op_c_i,
  input  logic [mult_pkg::SHIFT_W-1:0] imm_i,
  input  logic                         short_subword_i,
  input  logic [1:0]                   short_signed_i,

  // controls from the high-word sequencer
  input  logic                         mulh_active_i,
  input  logic [1:0]                   mulh_subword_i,
  input  logic [1:0]                   mulh_signed_i,
  input  logic [mult_pkg::SHIFT_W-1:0] mulh_imm_i,
  input  logic                         mulh_shift_arith_i,
  input  logic [mult_pkg::DATA_W-1:0]  mulh_acc_i,
  input  logic                         carry_i,

  output logic [mult_pkg::DATA_W-1:0]  result_o,
  output logic                         mac_carry_o
);

  // effective controls after the mulh mux
  logic [mult_pkg::SHIFT_W-1:0] short_imm;
  logic [1:0]                   short_subword;
  logic [1:0]                   short_signed;
  logic                         short_shift_arith;

  // operands and sums
  logic [mult_pkg::HALF_W:0]    short_op_a;
  logic [mult_pkg::HALF_W:0]    short_op_b;
  logic [mult_pkg::DATA_W:0]    short_op_c;
  logic [mult_pkg::DATA_W+1:0]  short_mul;
  logic [mult_pkg::DATA_W+1:0]  short_mac;
  logic [mult_pkg::DATA_W+1:0]  short_shifted;
  logic [mult_pkg::DATA_W-1:0]  round_tmp;
  logic [mult_pkg::DATA_W-1:0]  short_round;
  logic                         mac_msb1;
  logic                         mac_msb0;

  ////////////////////////////////////////////////////////////
  // control select
  ////////////////////////////////////////////////////////////

  // caller values when idle, sequencer values during mulh
  assign short_imm         = mulh_active_i ? mulh_imm_i : imm_i;
  assign short_subword     = mulh_active_i ? mulh_subword_i : {2{short_subword_i}};
  assign short_signed      = mulh_active_i ? mulh_signed_i : short_signed_i;
  // B signed with A unsigned is not a legal mode, bit 0 alone decides
  assign short_shift_arith = mulh_active_i ? mulh_shift_arith_i : short_signed_i[0];

  ////////////////////////////////////////////////////////////
  // operands
  ////////////////////////////////////////////////////////////

  // subword[0] picks the half of A, subword[1] the half of B
  assign short_op_a[mult_pkg::HALF_W-1:0] = short_subword[0] ?
      op_a_i[mult_pkg::DATA_W-1:mult_pkg::HALF_W] : op_a_i[mult_pkg::HALF_W-1:0];
  assign short_op_b[mult_pkg::HALF_W-1:0] = short_subword[1] ?
      op_b_i[mult_pkg::DATA_W-1:mult_pkg::HALF_W] : op_b_i[mult_pkg::HALF_W-1:0];

  // 17th bit is the sign when that operand is signed
  assign short_op_a[mult_pkg::HALF_W] = short_signed[0] & short_op_a[mult_pkg::HALF_W-1];
  assign short_op_b[mult_pkg::HALF_W] = short_signed[1] & short_op_b[mult_pkg::HALF_W-1];

  // addend
  // mulh feeds back the partial sum with its carry as bit 32
  assign short_op_c = mulh_active_i ? {carry_i, mulh_acc_i}
                                    : {op_c_i[mult_pkg::DATA_W-1], op_c_i};

  ////////////////////////////////////////////////////////////
  // rounding
  ////////////////////////////////////////////////////////////

  // half an lsb of the shifted result, zero for imm 0
  assign round_tmp   = {{(mult_pkg::DATA_W-1){1'b0}}, 1'b1} << imm_i;
  assign short_round = (operator_i == mult_pkg::MUL_IR) ?
                       {1'b0, round_tmp[mult_pkg::DATA_W-1:1]} : '0;

  ////////////////////////////////////////////////////////////
  // multiply, accumulate and shift
  ////////////////////////////////////////////////////////////

  assign short_mul = $signed(short_op_a) * $signed(short_op_b);

  // signed 34 bit sum, rounding term is always positive
  assign short_mac = $signed(short_op_c) + $signed(short_mul) + $signed({1'b0, short_round});

  // mulh keeps the real upper bits, otherwise bit 31 is the sign
  assign mac_msb1 = mulh_active_i ? short_mac[mult_pkg::DATA_W+1] : short_mac[mult_pkg::DATA_W-1];
  assign mac_msb0 = mulh_active_i ? short_mac[mult_pkg::DATA_W] : short_mac[mult_pkg::DATA_W-1];

  // logical shift when the upper bits are forced to zero
  assign short_shifted = $signed({short_shift_arith & mac_msb1,
                                  short_shift_arith & mac_msb0,
                                  short_mac[mult_pkg::DATA_W-1:0]}) >>> short_imm;

  assign result_o    = short_shifted[mult_pkg::DATA_W-1:0];
  assign mac_carry_o = short_mac[mult_pkg::DATA_W];

endmodule

`default_nettype wire

//--- hdl/int_mac.sv
////////////////////////////////////////////////////////////
// 32x32 integer multiply-accumulate
// c + a*b or c - a*b, low 32 bits only
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module int_mac (
  input  mult_pkg::mult_op_e          operator_i,
  input  logic [mult_pkg::DATA_W-1:0] op_a_i,
  input  logic [mult_pkg::DATA_W-1:0] op_b_i,
  input  logic [mult_pkg::DATA_W-1:0] op_c_i,
  output logic [mult_pkg::DATA_W-1:0] result_o
);

  logic                        is_msu;
  logic [mult_pkg::DATA_W-1:0] op_a_msu;
  logic [mult_pkg::DATA_W-1:0] op_b_corr;
  logic [mult_pkg::DATA_W-1:0] product;

  assign is_msu = (operator_i == mult_pkg::MUL_MSU32);

  // negated product without a second multiplier
  // (~a)*b + b = (-a-1)*b + b = -a*b
  assign op_a_msu  = op_a_i ^ {mult_pkg::DATA_W{is_msu}};
  assign op_b_corr = op_b_i & {mult_pkg::DATA_W{is_msu}};

  // only the low word is kept so signedness does not matter
  assign product = op_a_msu * op_b_i;

  // accumulate modulo 2^32
  assign result_o = op_c_i + op_b_corr + product;

endmodule

`default_nettype wire

//--- common/mult_pkg.sv
////////////////////////////////////////////////////////////
// multiplier package
// opcode and FSM state encodings for the integer MAC unit
// and the widths of the 16/32/64-bit high-word split
////////////////////////////////////////////////////////////

`default_nettype none

package mult_pkg;

  // operand and result width
  localparam int unsigned DATA_W = 32;

  // subword width of the short multiplier
  localparam int unsigned HALF_W = 16;

  // width of the immediate shift amount
  localparam int unsigned SHIFT_W = 5;

  // right shift after the AL*BL and AH*BL partial products
  localparam logic [SHIFT_W-1:0] MULH_STEP_SHIFT = 5'd16;

  // multiplier opcodes
  // encodings follow the core decoder, the gaps held the dot products
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'b000,
    MUL_MSU32 = 3'b001,
    MUL_I     = 3'b010,
    MUL_IR    = 3'b011,
    MUL_H     = 3'b110
  } mult_op_e;

  // high-word sequencer states
  // one partial product per state after IDLE
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    STEP0  = 3'd1,
    STEP1  = 3'd2,
    STEP2  = 3'd3,
    FINISH = 3'd4
  } mulh_state_e;

endpackage

`default_nettype wire
